// File: src/sampler_config.svh
`ifndef SAMPLER_CONFIG_SVH
`define SAMPLER_CONFIG_SVH

// base sampling period, counted in qualified ext_trig cycles.
`define SAMPLE_PERIOD_WI 8

// downsampling ratio, counted in base sample pulses.
`define DSAMPLE_WI 8

// signed adc word.
`define ADC_WI 16

// boxcar sum holds up to 2**DSAMPLE_WI samples without overflow.
`define SUM_WI (`ADC_WI + `DSAMPLE_WI)

// host register address.
`define REG_ADDR_WI 2

// number of downsampling channels.
`define N_DSAMPLE 3

`endif

// File: src/sampler_pkg.sv
`default_nettype none

`include "sampler_config.svh"

package sampler_pkg;

   // register map, one opcode per host address.
   typedef enum logic [`REG_ADDR_WI-1:0] {
      op_base_period = 2'd0,
      op_dsample0    = 2'd1,
      op_dsample1    = 2'd2,
      op_dsample2    = 2'd3
   } reg_op_t;

   // configuration held by the register block.
   typedef struct packed {
      logic [`SAMPLE_PERIOD_WI-1:0]           sample_period;
      logic [`N_DSAMPLE-1:0][`DSAMPLE_WI-1:0] dsample_period;
   } sampler_cfg_t;

   // dsample_stb bits only ever fire together with sample.
   typedef struct packed {
      logic                  sample;
      logic [`N_DSAMPLE-1:0] dsample_stb;
   } strobe_t;

   // per-channel boxcar results, each sum is two's complement.
   typedef struct packed {
      logic [`N_DSAMPLE-1:0]              valid;
      logic [`N_DSAMPLE-1:0][`SUM_WI-1:0] sum;
   } result_t;

endpackage

`default_nettype wire

// File: src/reg_decode.sv
`timescale 1ns/100ps
`default_nettype none

`include "sampler_config.svh"

module reg_decode (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      wr_stb,
   input  logic [`REG_ADDR_WI-1:0]   wr_addr,
   input  logic [15:0]               wr_data,
   output sampler_pkg::sampler_cfg_t cfg
);

   // reset values give a sample on every trigger and no downsampling.
   localparam logic [`SAMPLE_PERIOD_WI-1:0] BASE_PERIOD_RST = 1;
   localparam logic [`DSAMPLE_WI-1:0]       DSAMPLE_RST     = 1;

   sampler_pkg::reg_op_t      op;
   sampler_pkg::sampler_cfg_t cfg_r;

   // address to opcode map.
   function automatic sampler_pkg::reg_op_t addr_to_op(
      input logic [`REG_ADDR_WI-1:0] addr
   );
      sampler_pkg::reg_op_t res;
      case (addr)
         2'd0:    res = sampler_pkg::op_base_period;
         2'd1:    res = sampler_pkg::op_dsample0;
         2'd2:    res = sampler_pkg::op_dsample1;
         default: res = sampler_pkg::op_dsample2;
      endcase
      return res;
   endfunction

   assign op = addr_to_op(wr_addr);

   // writes take effect on the next edge.
   always_ff @(posedge clk) begin
      if (reset) begin
         cfg_r.sample_period <= BASE_PERIOD_RST;
         for (int k = 0; k < `N_DSAMPLE; k++) begin
            cfg_r.dsample_period[k] <= DSAMPLE_RST;
         end
      end else if (wr_stb) begin
         case (op)
            sampler_pkg::op_base_period: begin
               cfg_r.sample_period <= wr_data[`SAMPLE_PERIOD_WI-1:0];
            end
            sampler_pkg::op_dsample0: begin
               cfg_r.dsample_period[0] <= wr_data[`DSAMPLE_WI-1:0];
            end
            sampler_pkg::op_dsample1: begin
               cfg_r.dsample_period[1] <= wr_data[`DSAMPLE_WI-1:0];
            end
            sampler_pkg::op_dsample2: begin
               cfg_r.dsample_period[2] <= wr_data[`DSAMPLE_WI-1:0];
            end
         endcase
      end
   end

   // zero values pass through unchanged and the sampler treats them as 1.
   assign cfg = cfg_r;

endmodule

`default_nettype wire

// File: src/multi_sampler.sv
`timescale 1ns/100ps
`default_nettype none

`include "sampler_config.svh"

module multi_sampler (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      ext_trig,
   input  sampler_pkg::sampler_cfg_t cfg,
   output sampler_pkg::strobe_t      stb
);

   localparam logic [`SAMPLE_PERIOD_WI-1:0] BASE_ONE = 1;
   localparam logic [`DSAMPLE_WI-1:0]       DS_ONE   = 1;

   logic [`SAMPLE_PERIOD_WI-1:0]           period_eff;
   logic [`SAMPLE_PERIOD_WI-1:0]           samp_per_r;   // period seen at last trigger.
   logic [`SAMPLE_PERIOD_WI-1:0]           base_count;
   logic                                   period_changed;
   logic                                   base_wrap;
   logic                                   sample_r;
   logic [`N_DSAMPLE-1:0][`DSAMPLE_WI-1:0] ratio_eff;
   logic [`N_DSAMPLE-1:0][`DSAMPLE_WI-1:0] ds_count;
   logic [`N_DSAMPLE-1:0]                  ds_hit;

   // a period of 0 behaves as 1.
   assign period_eff = (cfg.sample_period == '0) ? BASE_ONE : cfg.sample_period;

   // restart only matters once the count has moved off zero.
   assign period_changed = (cfg.sample_period != samp_per_r) && (base_count != '0);
   assign base_wrap      = (base_count == period_eff - BASE_ONE);

   // base counter, advances on qualifying trigger cycles only.
   always_ff @(posedge clk) begin
      if (reset) begin
         samp_per_r <= '0;
         base_count <= '0;
         sample_r   <= 1'b0;
      end else begin
         // pulse is one cycle after a trigger that found the count at zero.
         sample_r <= ext_trig && (base_count == '0);
         if (ext_trig) begin
            samp_per_r <= cfg.sample_period;
            if (period_changed || base_wrap)
               base_count <= '0;
            else
               base_count <= base_count + BASE_ONE;
         end
      end
   end

   // downsampling counters.
   // each channel fires on the pulse where its count sits at 1,
   // then reloads its ratio, so the first pulse after reset fires all of them.
   always_comb begin
      for (int k = 0; k < `N_DSAMPLE; k++) begin
         ratio_eff[k] = (cfg.dsample_period[k] == '0) ? DS_ONE : cfg.dsample_period[k];
         ds_hit[k]    = (ds_count[k] == DS_ONE);
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int k = 0; k < `N_DSAMPLE; k++) begin
            ds_count[k] <= DS_ONE;
         end
      end else if (sample_r) begin
         for (int k = 0; k < `N_DSAMPLE; k++) begin
            if (ds_hit[k])
               ds_count[k] <= ratio_eff[k];          // reload.
            else
               ds_count[k] <= ds_count[k] - DS_ONE;
         end
      end
   end

   assign stb.sample      = sample_r;
   assign stb.dsample_stb = ds_hit & {`N_DSAMPLE{sample_r}};  // aligned with the pulse.

endmodule

`default_nettype wire

// File: src/boxcar_decimator.sv
`timescale 1ns/100ps
`default_nettype none

`include "sampler_config.svh"

module boxcar_decimator (
   input  logic                        clk,
   input  logic                        reset,
   input  sampler_pkg::strobe_t        stb,
   input  logic signed [`ADC_WI-1:0]   adc_data,
   output sampler_pkg::result_t        result
);

   logic signed [`SUM_WI-1:0]          adc_ext;
   logic signed [`SUM_WI-1:0]          acc      [`N_DSAMPLE];
   logic signed [`SUM_WI-1:0]          acc_next [`N_DSAMPLE];
   logic [`N_DSAMPLE-1:0]              fire;
   logic [`N_DSAMPLE-1:0]              valid_r;
   logic [`N_DSAMPLE-1:0][`SUM_WI-1:0] sum_r;

   assign adc_ext = adc_data;  // sign extends.

   // a channel closes its window only on a sample pulse.
   assign fire = stb.dsample_stb & {`N_DSAMPLE{stb.sample}};

   // running sum including the sample of this pulse.
   always_comb begin
      for (int k = 0; k < `N_DSAMPLE; k++) begin
         acc_next[k] = acc[k] + adc_ext;
      end
   end

   // accumulators and valid flags.
   always_ff @(posedge clk) begin
      if (reset) begin
         valid_r <= '0;
         for (int k = 0; k < `N_DSAMPLE; k++) begin
            acc[k] <= '0;
         end
      end else begin
         valid_r <= fire;  // single-cycle valid per closed window.
         if (stb.sample) begin
            for (int k = 0; k < `N_DSAMPLE; k++) begin
               if (fire[k])
                  acc[k] <= '0;         // start a new window.
               else
                  acc[k] <= acc_next[k];
            end
         end
      end
   end

   // captured sums, qualified by valid_r.
   always_ff @(posedge clk) begin
      for (int k = 0; k < `N_DSAMPLE; k++) begin
         if (fire[k])
            sum_r[k] <= acc_next[k];
      end
   end

   assign result.valid = valid_r;
   assign result.sum   = sum_r;

endmodule

`default_nettype wire

// File: src/sampler_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "sampler_config.svh"

module sampler_top (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      ext_trig,
   input  logic                      wr_stb,
   input  logic [`REG_ADDR_WI-1:0]   wr_addr,
   input  logic [15:0]               wr_data,
   input  logic signed [`ADC_WI-1:0] adc_data,
   output sampler_pkg::strobe_t      stb,
   output sampler_pkg::result_t      result
);

   sampler_pkg::sampler_cfg_t cfg;  // register block to sampler.

   // host register writes.
   reg_decode reg_decode_i (
      .clk     (clk),
      .reset   (reset),
      .wr_stb  (wr_stb),
      .wr_addr (wr_addr),
      .wr_data (wr_data),
      .cfg     (cfg)
   );

   // trigger to strobes, 1 cycle.
   multi_sampler multi_sampler_i (
      .clk      (clk),
      .reset    (reset),
      .ext_trig (ext_trig),
      .cfg      (cfg),
      .stb      (stb)
   );

   // strobes to results, 1 more cycle.
   boxcar_decimator boxcar_decimator_i (
      .clk      (clk),
      .reset    (reset),
      .stb      (stb),
      .adc_data (adc_data),
      .result   (result)
   );

endmodule

`default_nettype wire

// File: sim/sampler_sva.sv
`timescale 1ns/100ps
`default_nettype none

module sampler_sva (
   input logic                 clk,
   input logic                 reset,
   input logic                 ext_trig,
   input sampler_pkg::strobe_t stb
);

   // downsampling strobes only ride on a base sample pulse.
   dsample_needs_sample: assert property (
      @(posedge clk) disable iff (reset)
      (|stb.dsample_stb) |-> stb.sample
   ) else $error("dsample strobe high without a sample pulse");

   // a pulse needs a trigger in the cycle before it.
   no_pulse_without_trig: assert property (
      @(posedge clk) disable iff (reset)
      (stb.sample && !ext_trig) |=> !stb.sample
   ) else $error("sample pulse repeated without ext_trig");

   // reset clears every strobe.
   strobes_clear_after_reset: assert property (
      @(posedge clk)
      reset |=> (stb == '0)
   ) else $error("strobes not cleared after reset");

endmodule

bind multi_sampler sampler_sva sampler_sva_i (
   .clk      (clk),
   .reset    (reset),
   .ext_trig (ext_trig),
   .stb      (stb)
);

`default_nettype wire

// File: sim/sampler_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "sampler_config.svh"

module sampler_tb;

   localparam int CLK_PERIOD   = 8;
   localparam int RESET_CYCLES = 8;
   localparam int T1_CYCLES    = 40;
   localparam int T2_CYCLES    = 240;
   localparam int T3_CYCLES    = 60;
   localparam int T4_CYCLES    = 120;
   localparam int T5_CYCLES    = 400;
   localparam int EXTRA_CYCLES = 120;  // writes, waits, idle tail.
   localparam int TOTAL_CYCLES = 2 * RESET_CYCLES + T1_CYCLES + T2_CYCLES + T3_CYCLES
                                 + T4_CYCLES + T5_CYCLES + EXTRA_CYCLES;

   // trigger patterns for run_cycles.
   localparam int TRIG_LOW  = 0;
   localparam int TRIG_HIGH = 1;
   localparam int TRIG_RAND = 2;

   // registered state of the reference model.
   typedef struct packed {
      sampler_pkg::sampler_cfg_t              cfg;
      logic [`SAMPLE_PERIOD_WI-1:0]           last_period;
      logic [`SAMPLE_PERIOD_WI-1:0]           base_count;
      logic                                   sample;
      logic [`N_DSAMPLE-1:0][`DSAMPLE_WI-1:0] ds_count;
      logic [`N_DSAMPLE-1:0][`SUM_WI-1:0]     acc;
      sampler_pkg::result_t                   res;
   } model_t;

   logic                      clk;
   logic                      reset;
   logic                      ext_trig;
   logic                      wr_stb;
   logic [`REG_ADDR_WI-1:0]   wr_addr;
   logic [15:0]               wr_data;
   logic signed [`ADC_WI-1:0] adc_data;
   sampler_pkg::strobe_t      stb;
   sampler_pkg::result_t      result;

   model_t      model;
   logic        checking;
   string       test_name;
   int unsigned seed;

   sampler_top dut_i (
      .clk      (clk),
      .reset    (reset),
      .ext_trig (ext_trig),
      .wr_stb   (wr_stb),
      .wr_addr  (wr_addr),
      .wr_data  (wr_data),
      .adc_data (adc_data),
      .stb      (stb),
      .result   (result)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   function automatic model_t model_reset();
      model_t st;
      st = '0;
      st.cfg.sample_period = 1;
      for (int k = 0; k < `N_DSAMPLE; k++) begin
         st.cfg.dsample_period[k] = 1;
         st.ds_count[k]           = 1;
      end
      return st;
   endfunction

   // strobes seen in the cycle that holds this state.
   function automatic sampler_pkg::strobe_t model_strobe(input model_t st);
      sampler_pkg::strobe_t s;
      s.sample = st.sample;
      for (int k = 0; k < `N_DSAMPLE; k++) begin
         s.dsample_stb[k] = st.sample && (st.ds_count[k] == 1);
      end
      return s;
   endfunction

   // one clock edge of the whole subsystem.
   function automatic model_t model_step(
      input model_t                    st,
      input logic                      trig,
      input logic                      wr,
      input logic [`REG_ADDR_WI-1:0]   addr,
      input logic [15:0]               data,
      input logic signed [`ADC_WI-1:0] adc
   );
      model_t               nx;
      sampler_pkg::strobe_t s;
      int                   per;
      int                   ratio;
      logic [`SUM_WI-1:0]   adc_ext;
      nx      = st;
      s       = model_strobe(st);
      adc_ext = {{`DSAMPLE_WI{adc[`ADC_WI-1]}}, adc};
      per     = (st.cfg.sample_period == 0) ? 1 : int'(st.cfg.sample_period);
      nx.sample = trig && (st.base_count == 0);
      if (trig) begin
         nx.last_period = st.cfg.sample_period;
         if (st.cfg.sample_period != st.last_period && st.base_count != 0)
            nx.base_count = 0;  // restart on a new period.
         else
            nx.base_count = (int'(st.base_count) + 1) % per;
      end
      nx.res.valid = s.dsample_stb;
      if (st.sample) begin
         for (int k = 0; k < `N_DSAMPLE; k++) begin
            ratio = (st.cfg.dsample_period[k] == 0) ? 1 : int'(st.cfg.dsample_period[k]);
            nx.ds_count[k] = (st.ds_count[k] == 1) ? ratio : st.ds_count[k] - 1;
            if (s.dsample_stb[k]) begin
               nx.res.sum[k] = st.acc[k] + adc_ext;
               nx.acc[k]     = '0;
            end else begin
               nx.acc[k] = st.acc[k] + adc_ext;
            end
         end
      end
      if (wr) begin
         case (addr)
            2'd0:    nx.cfg.sample_period     = data[`SAMPLE_PERIOD_WI-1:0];
            2'd1:    nx.cfg.dsample_period[0] = data[`DSAMPLE_WI-1:0];
            2'd2:    nx.cfg.dsample_period[1] = data[`DSAMPLE_WI-1:0];
            default: nx.cfg.dsample_period[2] = data[`DSAMPLE_WI-1:0];
         endcase
      end
      return nx;
   endfunction

   task automatic compare_strobe(
      input string                name,
      input sampler_pkg::strobe_t exp,
      input sampler_pkg::strobe_t act
   );
      if (act !== exp) begin
         $display("ERR %s stb expected %b actual %b", name, exp, act);
         $display("** FAIL **");
         $fatal(1, "strobe mismatch");
      end
   endtask

   // sums only count on the channels that are valid.
   task automatic compare_result(
      input string                name,
      input sampler_pkg::result_t exp,
      input sampler_pkg::result_t act
   );
      logic bad;
      bad = (act.valid !== exp.valid);
      for (int k = 0; k < `N_DSAMPLE; k++) begin
         if (exp.valid[k] && (act.sum[k] !== exp.sum[k]))
            bad = 1'b1;
      end
      if (bad) begin
         $display("ERR %s result expected valid=%b sum=%h actual valid=%b sum=%h",
                  name, exp.valid, exp.sum, act.valid, act.sum);
         $display("** FAIL **");
         $fatal(1, "result mismatch");
      end
   endtask

   // reference model follows every clock edge.
   always @(posedge clk) begin
      if (reset)
         model = model_reset();
      else
         model = model_step(model, ext_trig, wr_stb, wr_addr, wr_data, adc_data);
   end

   // outputs are compared mid-cycle.
   always @(negedge clk) begin
      if (checking) begin
         compare_strobe(test_name, model_strobe(model), stb);
         compare_result(test_name, model.res, result);
      end
   end

   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic write_reg(input logic [`REG_ADDR_WI-1:0] addr, input logic [15:0] data);
      wr_stb  = 1'b1;
      wr_addr = addr;
      wr_data = data;
      next_cycle();
      wr_stb  = 1'b0;
   endtask

   task automatic run_cycles(input int n, input int mode);
      for (int i = 0; i < n; i++) begin
         adc_data = $urandom;
         case (mode)
            TRIG_LOW:  ext_trig = 1'b0;
            TRIG_HIGH: ext_trig = 1'b1;
            default:   ext_trig = ($urandom % 4) != 0;  // mostly triggering.
         endcase
         next_cycle();
      end
   endtask

   task automatic wait_sample(input int max_cycles);
      int n;
      n = 0;
      while (stb.sample !== 1'b1) begin
         if (n == max_cycles) begin
            $display("no sample pulse within %0d cycles in test %s", max_cycles, test_name);
            $display("** FAIL **");
            $fatal(1, "missing sample pulse");
         end
         adc_data = $urandom;
         next_cycle();
         n++;
      end
   endtask

   task automatic apply_reset();
      reset = 1'b1;
      repeat (RESET_CYCLES) next_cycle();
      reset = 1'b0;
   endtask

   initial begin
      #(2 * TOTAL_CYCLES * CLK_PERIOD);
      $display("watchdog: the run timed out after %0d cycles", 2 * TOTAL_CYCLES);
      $display("** FAIL **");
      $fatal(1, "timeout");
   end

   initial begin
      seed      = $urandom(23710);
      model     = model_reset();
      checking  = 1'b0;
      test_name = "reset";
      reset     = 1'b1;
      ext_trig  = 1'b0;
      wr_stb    = 1'b0;
      wr_addr   = '0;
      wr_data   = '0;
      adc_data  = '0;
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      reset    = 1'b0;
      checking = 1'b1;

      test_name = "defaults";
      run_cycles(T1_CYCLES, TRIG_HIGH);

      test_name = "base_period";
      ext_trig  = 1'b0;
      write_reg(2'd0, 16'd5);
      run_cycles(T2_CYCLES, TRIG_RAND);
      run_cycles(20, TRIG_LOW);  // pulses must stop.

      test_name = "period_restart";
      ext_trig  = 1'b1;
      wait_sample(20);
      run_cycles(2, TRIG_HIGH);  // count now off zero.
      ext_trig  = 1'b0;
      write_reg(2'd0, 16'd3);
      ext_trig  = 1'b1;
      wait_sample(10);
      run_cycles(T3_CYCLES, TRIG_HIGH);

      test_name = "dsample_ratios";
      ext_trig  = 1'b0;
      apply_reset();
      write_reg(2'd1, 16'd2);
      write_reg(2'd2, 16'd3);
      write_reg(2'd3, 16'd7);
      run_cycles(T4_CYCLES / 2, TRIG_HIGH);
      run_cycles(T4_CYCLES / 2, TRIG_RAND);

      // ch1 ratio 0 acts as 1, ch0 and ch2 line up every 4th pulse.
      test_name = "boxcar_sums";
      ext_trig  = 1'b0;
      write_reg(2'd0, 16'd2);
      write_reg(2'd1, 16'd4);
      write_reg(2'd2, 16'd0);
      write_reg(2'd3, 16'd2);
      run_cycles(T5_CYCLES / 2, TRIG_RAND);
      write_reg(2'd0, 16'd1);
      write_reg(2'd3, 16'd5);
      run_cycles(T5_CYCLES / 2, TRIG_RAND);

      test_name = "drain";
      run_cycles(10, TRIG_LOW);
      $display("** PASS **");
      $finish;
   end

endmodule

`default_nettype wire

// File: sampler_timing.f
+incdir+src
src/sampler_pkg.sv
src/reg_decode.sv
src/multi_sampler.sv
src/boxcar_decimator.sv
src/sampler_top.sv
sim/sampler_sva.sv
sim/sampler_tb.sv

// File: Bender.yml
package:
  name: sampler_timing

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/sampler_pkg.sv
      - src/reg_decode.sv
      - src/multi_sampler.sv
      - src/boxcar_decimator.sv
      - src/sampler_top.sv
  - target: simulation
    files:
      - sim/sampler_sva.sv
      - sim/sampler_tb.sv
